// ==== Makefile ====
# Verilator build for the rename and retirement slice.
# Any variable can be overridden on the command line, for example make sim LOG=run.log

VERILATOR  ?= verilator
FILELIST   ?= project.f
TB_TOP     ?= tb_rename_core
RTL_TOP    ?= rename_core_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= TEST PASS
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/rename_defines.svh ====
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// architectural register file
`define ARCH_REGS      32
`define REG_ADDR_WIDTH 5
`define DATA_WIDTH     32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reorder buffer where a tag is the slot index plus one
`define ROB_DEPTH      8
`define ROB_IDX_WIDTH  3
`define TAG_WIDTH      4

`endif

// ==== project.f ====
+incdir+include
source/rename_types_pkg.sv
source/flush_ctrl_pkg.sv
source/rename_ifs.sv
source/rob_ptr_counter.sv
source/rename_regfile.sv
source/reorder_buffer.sv
source/flush_ctrl.sv
source/rename_core_top.sv
sim/tb_rename_core.sv

// ==== sim/tb_rename_core.sv ====
`include "rename_defines.svh"

module tb_rename_core;
    timeunit 1ns;
    timeprecision 1ps;

    import rename_types_pkg::*;
    import flush_ctrl_pkg::*;

    localparam int max_cycles = 2000; // the whole sequence needs a few hundred cycles.

    typedef struct packed {
        rob_tag_t  tag;
        arch_reg_t rd;
        logic      wr;
        logic      done;
        data_t     value;
    } entry_t;

    logic      clk, rst;
    logic      disp_valid, disp_ready, disp_writes_rd;
    arch_reg_t disp_rd, disp_rs1, disp_rs2, iss_rd, cmt_rd;
    logic      iss_valid, wb_valid, cmt_valid, flush_valid, flush_busy;
    rob_tag_t  iss_tag, iss_rs1_tag, iss_rs2_tag, wb_tag, cmt_tag, flush_tag;
    data_t     iss_rs1_value, iss_rs2_value, wb_value, cmt_value;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    data_t        shadow_val [`ARCH_REGS] = '{default: '0};
    rob_tag_t     shadow_tag [`ARCH_REGS] = '{default: '0};
    entry_t       inflight [$];   // oldest entry at the front.
    int           tail_idx = 0;
    rob_tag_t     held_flush_tag;
    flush_state_t fstate = RUN;

    string test_name;
    int    tests = 0;
    int    checks = 0;
    int    errors = 0;
    int    errors_at_start = 0;
    int    cycles = 0;

    rename_core_top i_rename_core_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic void compare(input string what, input data_t expected,
                                    input data_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endfunction

    function automatic logic model_ready();
        return fstate == RUN && inflight.size() < `ROB_DEPTH;
    endfunction

    function automatic arch_reg_t random_reg();
        return arch_reg_t'($urandom_range(31, 1));
    endfunction

    // a pending tag whose entry is done reads as its value with tag 0.
    function automatic void read_operand(input arch_reg_t rs, output data_t v,
                                         output rob_tag_t t);
        v = (rs == '0) ? '0 : shadow_val[rs];
        t = (rs == '0) ? '0 : shadow_tag[rs];
        foreach (inflight[i]) begin
            if (t != '0 && inflight[i].tag == t && inflight[i].done) begin
                v = inflight[i].value;
                t = '0;
            end
        end
    endfunction

    function automatic void mark_done(input rob_tag_t t, input data_t v);
        foreach (inflight[i]) begin
            if (inflight[i].tag == t) begin
                inflight[i].done  = 1'b1;
                inflight[i].value = v;
            end
        end
    endfunction

    // one clock with the inputs already driven, model update at the edge, checks after it.
    task automatic tick();
        logic     fire;
        logic     retire;
        int       pre_size;
        entry_t   head_ent;
        entry_t   new_ent;
        data_t    v1, v2;
        rob_tag_t t1, t2;
        fire     = disp_valid && model_ready();
        retire   = inflight.size() > 0 && inflight[0].done && fstate != CLEAR;
        pre_size = inflight.size();
        read_operand(disp_rs1, v1, t1);
        read_operand(disp_rs2, v2, t2);
        @(posedge clk);
        if (retire) begin
            head_ent = inflight.pop_front();
            if (head_ent.wr && head_ent.rd != '0) begin
                shadow_val[head_ent.rd] = head_ent.value;
                if (shadow_tag[head_ent.rd] == head_ent.tag) begin
                    shadow_tag[head_ent.rd] = '0;
                end
            end
        end
        if (wb_valid) begin
            mark_done(wb_tag, wb_value);
        end
        if (fire) begin
            new_ent = '{tag: rob_tag_t'(tail_idx + 1), rd: disp_rd, wr: disp_writes_rd,
                        done: 1'b0, value: '0};
            inflight.push_back(new_ent);
            if (disp_writes_rd && disp_rd != '0) begin
                shadow_tag[disp_rd] = new_ent.tag;
            end
            tail_idx = (tail_idx + 1) % `ROB_DEPTH;
        end
        if (fstate == RUN && flush_valid) begin
            held_flush_tag = flush_tag;
            if (pre_size == 0 || (retire && head_ent.tag == flush_tag)) begin
                fstate = CLEAR;
            end else begin
                fstate = DRAIN;
            end
        end else if (fstate == DRAIN && retire && head_ent.tag == held_flush_tag) begin
            fstate = CLEAR;
        end else if (fstate == CLEAR) begin
            inflight.delete(); // younger entries are dropped.
            foreach (shadow_tag[i]) begin
                shadow_tag[i] = '0;
            end
            tail_idx = 0;
            fstate   = RUN;
        end
        @(negedge clk);
        compare("disp_ready", data_t'(model_ready()), data_t'(disp_ready));
        compare("flush_busy", data_t'(fstate != RUN), data_t'(flush_busy));
        compare("iss_valid", data_t'(fire), data_t'(iss_valid));
        compare("cmt_valid", data_t'(retire), data_t'(cmt_valid));
        if (fire) begin
            compare("iss_tag", data_t'(new_ent.tag), data_t'(iss_tag));
            compare("iss_rd", data_t'(disp_rd), data_t'(iss_rd));
            compare("iss_rs1_tag", data_t'(t1), data_t'(iss_rs1_tag));
            compare("iss_rs2_tag", data_t'(t2), data_t'(iss_rs2_tag));
            if (t1 == '0) begin
                compare("iss_rs1_value", v1, iss_rs1_value);
            end
            if (t2 == '0) begin
                compare("iss_rs2_value", v2, iss_rs2_value);
            end
        end
        if (retire) begin
            compare("cmt_rd", data_t'(head_ent.rd), data_t'(cmt_rd));
            compare("cmt_value", head_ent.value, cmt_value);
            compare("cmt_tag", data_t'(head_ent.tag), data_t'(cmt_tag));
        end
        disp_valid  = 1'b0;
        wb_valid    = 1'b0;
        flush_valid = 1'b0;
    endtask

    task automatic dispatch(input arch_reg_t rd, input arch_reg_t rs1, input arch_reg_t rs2,
                            input logic wr);
        while (!disp_ready) begin
            tick();
        end
        disp_valid     = 1'b1;
        disp_rd        = rd;
        disp_rs1       = rs1;
        disp_rs2       = rs2;
        disp_writes_rd = wr;
        tick();
    endtask

    task automatic writeback(input rob_tag_t t, input data_t v);
        wb_valid = 1'b1;
        wb_tag   = t;
        wb_value = v;
        tick();
    endtask

    // results come back in random order, then the buffer runs empty.
    task automatic drain();
        rob_tag_t pend [$];
        int       pick;
        foreach (inflight[i]) begin
            if (!inflight[i].done) begin
                pend.push_back(inflight[i].tag);
            end
        end
        while (pend.size() > 0) begin
            pick = $urandom_range(pend.size() - 1);
            writeback(pend[pick], $urandom);
            pend.delete(pick);
        end
        while (inflight.size() > 0 || fstate != RUN) begin
            tick();
        end
    endtask

    task automatic read_all();
        for (int k = 0; k < `ARCH_REGS / 2; k++) begin
            dispatch('0, arch_reg_t'(2 * k), arch_reg_t'(2 * k + 1), 1'b0);
            drain();
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("%s: %s, %0d errors", test_name,
                 (errors == errors_at_start) ? "ok" : "failed", errors - errors_at_start);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    initial begin
        arch_reg_t r;
        void'($urandom(10848));
        rst            = 1'b1;
        disp_valid     = 1'b0;
        disp_rd        = '0;
        disp_rs1       = '0;
        disp_rs2       = '0;
        disp_writes_rd = 1'b0;
        wb_valid       = 1'b0;
        wb_tag         = '0;
        wb_value       = '0;
        flush_valid    = 1'b0;
        flush_tag      = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test("reset");
        tick();
        read_all();
        end_test();

        begin_test("rename");
        r = random_reg();
        dispatch(r, random_reg(), random_reg(), 1'b1);
        dispatch(r, random_reg(), random_reg(), 1'b0); // no rename, so the tag stays.
        dispatch(random_reg(), r, r, 1'b1);
        drain();
        end_test();

        begin_test("forward");
        dispatch(random_reg(), random_reg(), random_reg(), 1'b1);
        r = random_reg();
        dispatch(r, random_reg(), random_reg(), 1'b1);
        writeback(inflight[1].tag, $urandom);
        dispatch(random_reg(), r, random_reg(), 1'b0);
        drain();
        end_test();

        begin_test("retire");
        r = random_reg();
        dispatch(r, random_reg(), random_reg(), 1'b1);
        dispatch(r, random_reg(), random_reg(), 1'b1);
        writeback(inflight[0].tag, $urandom);
        tick();
        dispatch(random_reg(), r, r, 1'b0); // the newer writer keeps its tag.
        drain();
        repeat (6) dispatch(arch_reg_t'($urandom_range(31, 0)), random_reg(), random_reg(),
                            1'($urandom_range(1, 0)));
        drain();
        end_test();

        begin_test("backpressure");
        repeat (`ROB_DEPTH) dispatch(random_reg(), random_reg(), random_reg(), 1'b1);
        disp_valid = 1'b1;
        tick();
        writeback(inflight[0].tag, $urandom);
        tick();
        drain();
        end_test();

        begin_test("flush");
        repeat (5) dispatch(random_reg(), random_reg(), random_reg(), 1'b1);
        flush_valid = 1'b1;
        flush_tag   = inflight[2].tag;
        tick();
        drain();
        read_all();
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== source/flush_ctrl.sv ====
module flush_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush_valid,
    input  rename_types_pkg::rob_tag_t flush_tag,
    commit_if.monitor                  commit,
    input  logic                       empty,
    output logic                       dispatch_block,
    output logic                       clear,
    output logic                       busy
);
    import rename_types_pkg::*;
    import flush_ctrl_pkg::*;

    flush_state_t state;
    flush_state_t state_next;
    rob_tag_t     flush_tag_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RUN;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == RUN && flush_valid) begin
            flush_tag_q <= flush_tag; // youngest entry that survives.
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            RUN: begin
                if (flush_valid) begin
                    if (empty || (commit.cmt_valid && commit.cmt_tag == flush_tag)) begin
                        state_next = CLEAR; // nothing left to drain.
                    end else begin
                        state_next = DRAIN;
                    end
                end
            end
            DRAIN: begin
                if (commit.cmt_valid && commit.cmt_tag == flush_tag_q) begin
                    state_next = CLEAR;
                end
            end
            CLEAR:   state_next = RUN;
            default: state_next = RUN;
        endcase
    end

    assign dispatch_block = (state != RUN);
    assign clear          = (state == CLEAR);
    assign busy           = (state != RUN);

endmodule

// ==== source/flush_ctrl_pkg.sv ====
package flush_ctrl_pkg;

    // recovery sequence after a misprediction.
    typedef enum logic [1:0] {
        RUN,   // normal dispatch.
        DRAIN, // retiring up to the flush point.
        CLEAR  // discarding speculative state.
    } flush_state_t;

endpackage

// ==== source/rename_core_top.sv ====
module rename_core_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        disp_valid,
    output logic                        disp_ready,
    input  rename_types_pkg::arch_reg_t disp_rd,
    input  rename_types_pkg::arch_reg_t disp_rs1,
    input  rename_types_pkg::arch_reg_t disp_rs2,
    input  logic                        disp_writes_rd,
    output logic                        iss_valid,
    output rename_types_pkg::rob_tag_t  iss_tag,
    output rename_types_pkg::arch_reg_t iss_rd,
    output rename_types_pkg::data_t     iss_rs1_value,
    output rename_types_pkg::rob_tag_t  iss_rs1_tag,
    output rename_types_pkg::data_t     iss_rs2_value,
    output rename_types_pkg::rob_tag_t  iss_rs2_tag,
    input  logic                        wb_valid,
    input  rename_types_pkg::rob_tag_t  wb_tag,
    input  rename_types_pkg::data_t     wb_value,
    output logic                        cmt_valid,
    output rename_types_pkg::arch_reg_t cmt_rd,
    output rename_types_pkg::data_t     cmt_value,
    output rename_types_pkg::rob_tag_t  cmt_tag,
    input  logic                        flush_valid,
    input  rename_types_pkg::rob_tag_t  flush_tag,
    output logic                        flush_busy
);
    import rename_types_pkg::*;

    alloc_if    alloc_bus ();
    rob_read_if rob_rd_bus ();
    commit_if   commit_bus ();

    logic     disp_fire;
    logic     dispatch_block;
    logic     rob_full;
    logic     rob_empty;
    logic     flush_clear;
    data_t    rs1_value;
    rob_tag_t rs1_tag;
    data_t    rs2_value;
    rob_tag_t rs2_tag;

    assign disp_ready = !dispatch_block && !rob_full;
    assign disp_fire  = disp_valid && disp_ready;

    rename_regfile i_rename_regfile (
        .clk       (clk),
        .rst       (rst),
        .disp_rs1  (disp_rs1),
        .disp_rs2  (disp_rs2),
        .alloc     (alloc_bus.sink),
        .rob_rd    (rob_rd_bus.requester),
        .commit    (commit_bus.sink),
        .clear     (flush_clear),
        .rs1_value (rs1_value),
        .rs1_tag   (rs1_tag),
        .rs2_value (rs2_value),
        .rs2_tag   (rs2_tag)
    );

    reorder_buffer i_reorder_buffer (
        .clk            (clk),
        .rst            (rst),
        .disp_fire      (disp_fire),
        .disp_rd        (disp_rd),
        .disp_writes_rd (disp_writes_rd),
        .alloc          (alloc_bus.source),
        .rob_rd         (rob_rd_bus.responder),
        .wb_valid       (wb_valid),
        .wb_tag         (wb_tag),
        .wb_value       (wb_value),
        .commit         (commit_bus.source),
        .clear          (flush_clear),
        .full           (rob_full),
        .empty          (rob_empty)
    );

    flush_ctrl i_flush_ctrl (
        .clk            (clk),
        .rst            (rst),
        .flush_valid    (flush_valid),
        .flush_tag      (flush_tag),
        .commit         (commit_bus.monitor),
        .empty          (rob_empty),
        .dispatch_block (dispatch_block),
        .clear          (flush_clear),
        .busy           (flush_busy)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // issue and commit output registers

    always_ff @(posedge clk) begin
        if (rst) begin
            iss_valid <= 1'b0;
            cmt_valid <= 1'b0;
        end else begin
            iss_valid <= disp_fire;
            cmt_valid <= commit_bus.cmt_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_fire) begin
            iss_tag       <= alloc_bus.alloc_tag; // operands as read at the transfer edge.
            iss_rd        <= disp_rd;
            iss_rs1_value <= rs1_value;
            iss_rs1_tag   <= rs1_tag;
            iss_rs2_value <= rs2_value;
            iss_rs2_tag   <= rs2_tag;
        end
        if (commit_bus.cmt_valid) begin
            cmt_rd    <= commit_bus.cmt_rd;
            cmt_value <= commit_bus.cmt_value;
            cmt_tag   <= commit_bus.cmt_tag;
        end
    end

endmodule

// ==== source/rename_ifs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tag allocation from the buffer to the register file
interface alloc_if;
    import rename_types_pkg::*;

    logic      alloc_valid;
    arch_reg_t alloc_rd;
    logic      alloc_writes_rd;
    rob_tag_t  alloc_tag;

    modport source (output alloc_valid, alloc_rd, alloc_writes_rd, alloc_tag);
    modport sink   (input  alloc_valid, alloc_rd, alloc_writes_rd, alloc_tag);
endinterface

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operand forwarding lookup that is answered in the same cycle
interface rob_read_if;
    import rename_types_pkg::*;

    rob_tag_t rd_tag1;
    rob_tag_t rd_tag2;
    logic     rd_done1;
    data_t    rd_value1;
    logic     rd_done2;
    data_t    rd_value2;

    modport requester (output rd_tag1, rd_tag2,
                       input  rd_done1, rd_value1, rd_done2, rd_value2);
    modport responder (input  rd_tag1, rd_tag2,
                       output rd_done1, rd_value1, rd_done2, rd_value2);
endinterface

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// in-order retirement of the head entry
interface commit_if;
    import rename_types_pkg::*;

    logic      cmt_valid;
    arch_reg_t cmt_rd;
    data_t     cmt_value;
    rob_tag_t  cmt_tag;
    logic      cmt_writes_rd;

    modport source  (output cmt_valid, cmt_rd, cmt_value, cmt_tag, cmt_writes_rd);
    modport sink    (input  cmt_valid, cmt_rd, cmt_value, cmt_tag, cmt_writes_rd);
    modport monitor (input  cmt_valid, cmt_tag);
endinterface

// ==== source/rename_regfile.sv ====
`include "rename_defines.svh"

module rename_regfile (
    input  logic                        clk,
    input  logic                        rst,
    input  rename_types_pkg::arch_reg_t disp_rs1,
    input  rename_types_pkg::arch_reg_t disp_rs2,
    alloc_if.sink                       alloc,
    rob_read_if.requester               rob_rd,
    commit_if.sink                      commit,
    input  logic                        clear,
    output rename_types_pkg::data_t     rs1_value,
    output rename_types_pkg::rob_tag_t  rs1_tag,
    output rename_types_pkg::data_t     rs2_value,
    output rename_types_pkg::rob_tag_t  rs2_tag
);
    import rename_types_pkg::*;

    data_t    values [`ARCH_REGS];
    rob_tag_t tags   [`ARCH_REGS];

    logic cmt_write;
    logic alloc_write;

    assign cmt_write   = commit.cmt_valid && commit.cmt_writes_rd && (commit.cmt_rd != '0);
    assign alloc_write = alloc.alloc_valid && alloc.alloc_writes_rd && (alloc.alloc_rd != '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand read

    assign rob_rd.rd_tag1 = (disp_rs1 == '0) ? '0 : tags[disp_rs1];
    assign rob_rd.rd_tag2 = (disp_rs2 == '0) ? '0 : tags[disp_rs2];

    always_comb begin
        if (disp_rs1 == '0) begin
            rs1_value = '0; // x0 is hardwired.
            rs1_tag   = '0;
        end else if (rob_rd.rd_tag1 != '0 && rob_rd.rd_done1) begin
            rs1_value = rob_rd.rd_value1; // completed but not yet retired.
            rs1_tag   = '0;
        end else begin
            rs1_value = values[disp_rs1];
            rs1_tag   = rob_rd.rd_tag1;
        end
    end

    always_comb begin
        if (disp_rs2 == '0) begin
            rs2_value = '0;
            rs2_tag   = '0;
        end else if (rob_rd.rd_tag2 != '0 && rob_rd.rd_done2) begin
            rs2_value = rob_rd.rd_value2;
            rs2_tag   = '0;
        end else begin
            rs2_value = values[disp_rs2];
            rs2_tag   = rob_rd.rd_tag2;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // commit, rename and flush

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                values[i] <= '0;
                tags[i]   <= '0;
            end
        end else begin
            if (cmt_write) begin
                values[commit.cmt_rd] <= commit.cmt_value;
                if (tags[commit.cmt_rd] == commit.cmt_tag) begin
                    tags[commit.cmt_rd] <= '0; // a newer writer keeps its tag.
                end
            end
            if (alloc_write) begin
                tags[alloc.alloc_rd] <= alloc.alloc_tag; // wins over the commit clearing.
            end
            if (clear) begin
                for (int i = 0; i < `ARCH_REGS; i++) begin
                    tags[i] <= '0;
                end
            end
        end
    end

endmodule

// ==== source/rename_types_pkg.sv ====
`include "rename_defines.svh"

package rename_types_pkg;

    // architectural register number from x0 to x31.
    typedef logic [`REG_ADDR_WIDTH-1:0] arch_reg_t;

    // operand and result word.
    typedef logic [`DATA_WIDTH-1:0] data_t;

    // rename tag where zero means the register value is valid.
    typedef logic [`TAG_WIDTH-1:0] rob_tag_t;

    // slot index inside the reorder buffer.
    typedef logic [`ROB_IDX_WIDTH-1:0] rob_idx_t;

endpackage

// ==== source/reorder_buffer.sv ====
`include "rename_defines.svh"

module reorder_buffer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        disp_fire,
    input  rename_types_pkg::arch_reg_t disp_rd,
    input  logic                        disp_writes_rd,
    alloc_if.source                     alloc,
    rob_read_if.responder               rob_rd,
    input  logic                        wb_valid,
    input  rename_types_pkg::rob_tag_t  wb_tag,
    input  rename_types_pkg::data_t     wb_value,
    commit_if.source                    commit,
    input  logic                        clear,
    output logic                        full,
    output logic                        empty
);
    import rename_types_pkg::*;

    arch_reg_t             ent_rd        [`ROB_DEPTH];
    logic                  ent_writes_rd [`ROB_DEPTH];
    data_t                 ent_value     [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] ent_done;

    rob_idx_t head;
    rob_idx_t tail;
    rob_idx_t wb_idx;
    rob_idx_t rd_idx1;
    rob_idx_t rd_idx2;
    logic     wb_hit;
    logic     retire;

    function automatic rob_idx_t tag_to_idx(input rob_tag_t tag);
        rob_tag_t slot;
        slot = tag - rob_tag_t'(1);
        return slot[`ROB_IDX_WIDTH-1:0];
    endfunction

    function automatic rob_tag_t idx_to_tag(input rob_idx_t idx);
        return {1'b0, idx} + rob_tag_t'(1);
    endfunction

    rob_ptr_counter i_rob_ptr_counter (
        .clk   (clk),
        .rst   (rst),
        .push  (disp_fire),
        .pop   (retire),
        .clear (clear),
        .head  (head),
        .tail  (tail),
        .full  (full),
        .empty (empty)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // allocation at the tail

    assign alloc.alloc_valid     = disp_fire;
    assign alloc.alloc_rd        = disp_rd;
    assign alloc.alloc_writes_rd = disp_writes_rd;
    assign alloc.alloc_tag       = idx_to_tag(tail);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writeback and forwarding

    assign wb_idx = tag_to_idx(wb_tag);
    assign wb_hit = wb_valid && (wb_tag != '0);

    assign rd_idx1 = tag_to_idx(rob_rd.rd_tag1);
    assign rd_idx2 = tag_to_idx(rob_rd.rd_tag2);

    assign rob_rd.rd_done1  = (rob_rd.rd_tag1 != '0) && ent_done[rd_idx1];
    assign rob_rd.rd_value1 = ent_value[rd_idx1];
    assign rob_rd.rd_done2  = (rob_rd.rd_tag2 != '0) && ent_done[rd_idx2];
    assign rob_rd.rd_value2 = ent_value[rd_idx2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // in-order retirement

    assign retire = !empty && ent_done[head] && !clear; // younger entries die in clear.

    assign commit.cmt_valid     = retire;
    assign commit.cmt_rd        = ent_rd[head];
    assign commit.cmt_value     = ent_value[head];
    assign commit.cmt_tag       = idx_to_tag(head);
    assign commit.cmt_writes_rd = ent_writes_rd[head];

    always_ff @(posedge clk) begin
        if (disp_fire) begin
            ent_rd[tail]        <= disp_rd;
            ent_writes_rd[tail] <= disp_writes_rd;
        end
        if (wb_hit) begin
            ent_value[wb_idx] <= wb_value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            ent_done <= '0;
        end else begin
            if (disp_fire) begin
                ent_done[tail] <= 1'b0; // the slot may hold a stale done bit.
            end
            if (wb_hit) begin
                ent_done[wb_idx] <= 1'b1;
            end
        end
    end

endmodule

// ==== source/rob_ptr_counter.sv ====
`include "rename_defines.svh"

module rob_ptr_counter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  logic                       pop,
    input  logic                       clear,
    output rename_types_pkg::rob_idx_t head,
    output rename_types_pkg::rob_idx_t tail,
    output logic                       full,
    output logic                       empty
);
    import rename_types_pkg::*;

    localparam rob_idx_t                 last_idx    = rob_idx_t'(`ROB_DEPTH - 1);
    localparam logic [`ROB_IDX_WIDTH:0]  depth_count = `ROB_DEPTH;

    logic [`ROB_IDX_WIDTH:0] count; // one bit wider than an index to hold a full buffer.

    function automatic rob_idx_t next_ptr(input rob_idx_t ptr);
        return (ptr == last_idx) ? '0 : ptr + rob_idx_t'(1);
    endfunction

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= next_ptr(tail);
            end
            if (pop) begin
                head <= next_ptr(head);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither leave occupancy as is.
            endcase
        end
    end

    assign full  = (count == depth_count);
    assign empty = (count == '0);

endmodule
